// File: sources.f
logic/cpu_ops_pkg.sv
logic/seq_pkg.sv
logic/opcode_decoder.sv
logic/cycle_sequencer.sv
logic/address_mode_encoder.sv
logic/datapath_op_encoder.sv
logic/ctl_unit.sv
tests/ctl_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := ctl_unit_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/ctl_unit_tb.sv
// Testbench for the 65C02-style control unit
// Feeds random opcodes from a fixed list at each fetch and random bytes
// in between, then checks cadence, write timing and the operation outputs
// against a cycle model of the instruction state paths

module ctl_unit_tb;
    import cpu_ops_pkg::*;
    import seq_pkg::*;

    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 5 + 20;   // Longest class is 5 cycles
    localparam int NUM_OPS        = 17;
    localparam logic [1:0] IDX_NONE = 2'd0;
    localparam logic [1:0] IDX_X    = 2'd1;
    localparam logic [1:0] IDX_Y    = 2'd2;

    typedef enum logic [2:0] {CL_IMPL, CL_IMM, CL_ZP, CL_ABS, CL_BR} op_class_t;

    typedef struct packed {
        byte_t      opc;
        op_class_t  cls;
        logic       st;
        logic       rmw;
        logic       jmp;
        logic [1:0] idx;
        logic       ld;
        reg_dst_t   dst;
        reg_sel_t   src;
        flag_op_t   flags;
    } op_entry_t;

    logic      clk;
    logic      rst;
    byte_t     db;
    logic      cond;
    logic      sync;
    logic      we;
    flag_op_t  flag_op;
    alu_op_t   alu_op;
    reg_op_t   reg_op;
    ab_op_t    ab_op;

    op_entry_t    ops [NUM_OPS];
    op_entry_t    cur;          // Instruction held by the decoder
    op_entry_t    drv;          // Opcode on db in the current fetch
    cycle_state_t m_state;      // Model state
    int           cyc;          // Cycles since the last DUT sync
    int           n_instr;
    int           cycle_cnt = 0;

    ctl_unit uut (
        .clk     (clk),
        .rst     (rst),
        .db      (db),
        .cond    (cond),
        .sync    (sync),
        .we      (we),
        .flag_op (flag_op),
        .alu_op  (alu_op),
        .reg_op  (reg_op),
        .ab_op   (ab_op)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg_op(input string name, input reg_op_t got, input reg_op_t exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_t got, input alu_op_t exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag_op(input string name, input flag_op_t got, input flag_op_t exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Only the bits under mask are compared
    task automatic check_ab_op(input string name, input ab_op_t got, input ab_op_t exp,
                               input ab_op_t mask);
        if ((got & mask) !== (exp & mask)) begin
            $display("Mismatch at time %0t: %s got %h expected %h (mask %h)",
                     $time, name, got, exp, mask);
            abort_run();
        end
    endtask

    task automatic check_cycles(input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch at time %0t: cycles between syncs got %0d expected %0d",
                     $time, got, exp);
            abort_run();
        end
    endtask

    function automatic int expected_cycles(input op_entry_t e);
        case (e.cls)
            CL_IMM, CL_BR: return 2;
            CL_ZP:         return e.rmw ? 4 : 3;
            CL_ABS:        return e.jmp ? 3 : (e.rmw ? 5 : 4);
            default:       return 1;
        endcase
    endfunction

    function automatic reg_sel_t index_source(input logic [1:0] idx);
        case (idx)
            IDX_X:   return REG_X;
            IDX_Y:   return REG_Y;
            default: return REG_Z;
        endcase
    endfunction

    // Low-byte mux and carry straight from the mode of each state
    function automatic ab_op_t expected_ab(input cycle_state_t s, input logic c, input byte_t d);
        ab_mode_t mode;
        ab_op_t   e;
        case (s)
            SYNC, IMM0, ABS0: mode = MODE_NEXT;
            ZERO:             mode = MODE_ZP;
            ABS1:             mode = MODE_ABS;
            DATA:             mode = MODE_PC;
            COND:             mode = MODE_BRANCH;
            default:          mode = MODE_KEEP;
        endcase
        e = '0;
        e[4:3] = mode[1:0];
        e[0] = mode[2];
        if (s == COND)
            e[5] = c & d[7];    // Taken backward branch
        return e;
    endfunction

    task automatic verify_outputs();
        ab_op_t mask;
        mask = (m_state == COND) ? 12'h039 : 12'h019;
        if (sync === 1'b1) begin
            if (n_instr > 0)
                check_cycles(cyc, expected_cycles(cur));
            cyc = 0;
        end
        check_bit("sync", sync, m_state == SYNC);
        check_bit("we", we, (m_state == DATA) && (cur.st || cur.rmw));
        check_flag_op("flag_op", flag_op, cur.flags);
        check_ab_op("ab_op", ab_op, expected_ab(m_state, cond, db), mask);
        case (m_state)
            SYNC:       check_reg_op("reg_op", reg_op, {cur.ld, cur.dst, cur.src});
            ZERO, ABS1: check_reg_op("reg_op", reg_op, {3'b000, index_source(cur.idx)});
            IMM0, RDWR: check_alu_op("alu_op", alu_op, ALU_LOAD_M);
            DATA: begin
                check_reg_op("reg_op", reg_op, {1'b0, cur.dst, cur.src});
                if (cur.st)
                    check_alu_op("alu_op", alu_op, ALU_STORE);
            end
            default: ;
        endcase
    endtask

    task automatic advance_model();
        case (m_state)
            SYNC: begin
                cur = drv;
                n_instr++;
                case (drv.cls)
                    CL_IMM:  m_state = IMM0;
                    CL_ZP:   m_state = ZERO;
                    CL_ABS:  m_state = ABS0;
                    CL_BR:   m_state = COND;
                    default: m_state = SYNC;   // Implied
                endcase
            end
            ZERO:    m_state = cur.rmw ? RDWR : DATA;
            ABS0:    m_state = ABS1;
            ABS1:    m_state = cur.jmp ? SYNC : (cur.rmw ? RDWR : DATA);
            RDWR:    m_state = DATA;
            default: m_state = SYNC;   // INIT, IMM0, DATA and COND
        endcase
        cyc++;
    endtask

    task automatic drive_inputs();
        cond <= 1'($urandom);
        if (m_state == SYNC) begin
            drv = ops[$urandom_range(NUM_OPS - 1, 0)];
            db <= drv.opc;
        end else begin
            db <= 8'($urandom);
        end
    endtask

    initial begin
        clk  = 1'b0;
        rst  = 1'b1;
        db   = '0;
        cond = 1'b0;
        void'($urandom(32'haa45cf87));

        // opcode, class, st, rmw, jmp, index, ld, dst, src, flag mask
        ops[0]  = '{8'hA9, CL_IMM,  1'b0, 1'b0, 1'b0, IDX_NONE, 1'b1, 2'd2, REG_Z, 10'h218};
        ops[1]  = '{8'hA5, CL_ZP,   1'b0, 1'b0, 1'b0, IDX_NONE, 1'b1, 2'd2, REG_Z, 10'h218};
        ops[2]  = '{8'hB5, CL_ZP,   1'b0, 1'b0, 1'b0, IDX_X,    1'b1, 2'd2, REG_Z, 10'h218};
        ops[3]  = '{8'hB9, CL_ABS,  1'b0, 1'b0, 1'b0, IDX_Y,    1'b1, 2'd2, REG_Z, 10'h218};
        ops[4]  = '{8'h8D, CL_ABS,  1'b1, 1'b0, 1'b0, IDX_NONE, 1'b0, 2'd0, REG_A, 10'h000};
        ops[5]  = '{8'h95, CL_ZP,   1'b1, 1'b0, 1'b0, IDX_X,    1'b0, 2'd0, REG_A, 10'h000};
        ops[6]  = '{8'h96, CL_ZP,   1'b1, 1'b0, 1'b0, IDX_Y,    1'b0, 2'd0, REG_X, 10'h000};
        ops[7]  = '{8'h9C, CL_ABS,  1'b1, 1'b0, 1'b0, IDX_NONE, 1'b0, 2'd0, REG_Z, 10'h000};
        ops[8]  = '{8'hE6, CL_ZP,   1'b0, 1'b1, 1'b0, IDX_NONE, 1'b0, 2'd0, 4'd5,  10'h218};
        ops[9]  = '{8'h1E, CL_ABS,  1'b0, 1'b1, 1'b0, IDX_X,    1'b0, 2'd0, REG_Z, 10'h21B};
        ops[10] = '{8'h4C, CL_ABS,  1'b0, 1'b0, 1'b1, IDX_NONE, 1'b0, 2'd0, REG_Z, 10'h000};
        ops[11] = '{8'hD0, CL_BR,   1'b0, 1'b0, 1'b0, IDX_NONE, 1'b0, 2'd0, REG_X, 10'h000};
        ops[12] = '{8'h80, CL_BR,   1'b0, 1'b0, 1'b0, IDX_NONE, 1'b0, 2'd0, REG_X, 10'h000};
        ops[13] = '{8'hE8, CL_IMPL, 1'b0, 1'b0, 1'b0, IDX_NONE, 1'b1, 2'd0, REG_X, 10'h218};
        ops[14] = '{8'h18, CL_IMPL, 1'b0, 1'b0, 1'b0, IDX_NONE, 1'b0, 2'd0, REG_Z, 10'h003};
        ops[15] = '{8'hE0, CL_IMM,  1'b0, 1'b0, 1'b0, IDX_NONE, 1'b0, 2'd0, REG_X, 10'h21B};
        ops[16] = '{8'h2C, CL_ABS,  1'b0, 1'b0, 1'b0, IDX_NONE, 1'b0, 2'd0, REG_A, 10'h388};

        repeat (4) begin
            @(negedge clk);
            check_bit("sync", sync, 1'b0);
            check_bit("we", we, 1'b0);
        end

        cur     = '0;      // Decoder word is cleared by reset
        drv     = '0;
        m_state = INIT;
        cyc     = 0;
        n_instr = 0;
        @(posedge clk);
        rst <= 1'b0;
        drive_inputs();

        while (n_instr <= NUM_INSTR) begin
            @(negedge clk);
            verify_outputs();
            advance_model();
            @(posedge clk);
            drive_inputs();
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: logic/ctl_unit.sv
// Control unit of a 65C02-style core
// Decodes each fetched opcode, sequences its bus cycles and drives the
// address-path, register, ALU and flag operations plus write enable

module ctl_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_ops_pkg::byte_t    db,
    input  logic                  cond,
    output logic                  sync,
    output logic                  we,
    output cpu_ops_pkg::flag_op_t flag_op,
    output cpu_ops_pkg::alu_op_t  alu_op,
    output cpu_ops_pkg::reg_op_t  reg_op,
    output cpu_ops_pkg::ab_op_t   ab_op
);
    import cpu_ops_pkg::*;
    import seq_pkg::*;

    ctl_word_t    ctl;      // Word of the current instruction
    cycle_state_t state;

    opcode_decoder u_decoder (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .db    (db),
        .ctl   (ctl)
    );

    cycle_sequencer u_sequencer (
        .clk   (clk),
        .rst   (rst),
        .db    (db),
        .ctl   (ctl),
        .state (state),
        .sync  (sync)
    );

    address_mode_encoder u_ab_enc (
        .state (state),
        .cond  (cond),
        .db    (db),
        .ab_op (ab_op)
    );

    datapath_op_encoder u_dp_enc (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .ctl     (ctl),
        .we      (we),
        .reg_op  (reg_op),
        .alu_op  (alu_op),
        .flag_op (flag_op)
    );

endmodule

// File: logic/datapath_op_encoder.sv
// Datapath operation encoder
// Drives the register, ALU and flag operations for the current cycle
// from the latched control word, and times the memory write enable.
// An instruction's result is written back during the next SYNC

module datapath_op_encoder (
    input  logic                   clk,
    input  logic                   rst,
    input  seq_pkg::cycle_state_t  state,
    input  cpu_ops_pkg::ctl_word_t ctl,
    output logic                   we,
    output cpu_ops_pkg::reg_op_t   reg_op,
    output cpu_ops_pkg::alu_op_t   alu_op,
    output cpu_ops_pkg::flag_op_t  flag_op
);
    import cpu_ops_pkg::*;
    import seq_pkg::*;

    reg_sel_t idx_src;      // Index register for address calculation

    assign idx_src = ctl.add_x ? REG_X : (ctl.add_y ? REG_Y : REG_Z);
    assign flag_op = ctl.flag_op;

    always_comb begin
        case (state)
            SYNC:       reg_op = {ctl.ld, ctl.dst, ctl.src};   // dst <= src op M
            DATA:       reg_op = {1'b0, ctl.dst, ctl.src};     // Source for a store
            ZERO, ABS1: reg_op = {1'b0, 2'b00, idx_src};
            default:    reg_op = {1'b0, 2'b00, REG_Z};
        endcase
    end

    always_comb begin
        case (state)
            SYNC:       alu_op = {2'b10, ctl.alu};
            IMM0, RDWR: alu_op = ALU_LOAD_M;
            DATA: begin
                if (ctl.st)
                    alu_op = ALU_STORE;
                else if (ctl.rmw)
                    alu_op = {2'b00, ctl.alu};   // Modify result goes to memory
                else
                    alu_op = {2'b10, ctl.alu};
            end
            default:    alu_op = '0;
        endcase
    end

    // Raised for the cycle that follows, which is always DATA
    always_ff @(posedge clk) begin
        if (rst) begin
            we <= 1'b0;
        end else begin
            case (state)
                ZERO, ABS1: we <= ctl.st && !ctl.rmw && !ctl.jmp;
                RDWR:       we <= 1'b1;
                default:    we <= 1'b0;
            endcase
        end
    end

    a_we_in_data: assert property (@(posedge clk) disable iff (rst)
        we |-> state == DATA);

endmodule

// File: logic/address_mode_encoder.sv
// Address mode encoder
// Picks the address-path mode for each cycle state and expands it into
// the twelve ab_op control bits. In a branch the high-byte adjust
// follows the offset sign when the branch is taken

module address_mode_encoder (
    input  seq_pkg::cycle_state_t state,
    input  logic                  cond,
    input  cpu_ops_pkg::byte_t    db,
    output cpu_ops_pkg::ab_op_t   ab_op
);
    import seq_pkg::*;

    ab_mode_t   mode;
    logic [1:0] abl_sel;    // Low-byte mux select
    logic       abl_ci;     // Low-byte carry in
    logic       back;       // Taken backward branch

    always_comb begin
        case (state)
            SYNC, IMM0, ABS0: mode = MODE_NEXT;
            ZERO:             mode = MODE_ZP;
            ABS1:             mode = MODE_ABS;
            DATA:             mode = MODE_PC;
            COND:             mode = MODE_BRANCH;
            default:          mode = MODE_KEEP;    // INIT and RDWR
        endcase
    end

    assign abl_sel = mode[1:0];
    assign abl_ci  = mode[2];
    assign back    = cond & db[7];

    // Upper seven bits control PC hold, AHL and the high byte
    always_comb begin
        case (mode)
            MODE_PC:     ab_op = {7'b000_1010, abl_sel, 2'b10, abl_ci};   // Back to PC
            MODE_ABS:    ab_op = {7'b111_1110, abl_sel, 2'b01, abl_ci};   // {DB, AHL + reg}
            MODE_ZP:     ab_op = {7'b111_0000, abl_sel, 2'b01, abl_ci};   // {00, DB + reg}
            MODE_NEXT:   ab_op = {7'b011_0110, abl_sel, 2'b11, abl_ci};   // AB + 1
            MODE_BRANCH: ab_op = {6'b011_011, back, abl_sel, 2'b11, abl_ci};
            default:     ab_op = {7'b001_0110, abl_sel, 2'b11, abl_ci};   // AB + 0
        endcase
    end

endmodule

// File: logic/cycle_sequencer.sv
// Cycle sequencer
// Steps the bus cycles of each instruction, one state per clock.
// The opcode on db is classified by column pattern in SYNC, and the
// decoded rmw and jmp bits choose the exits of ZERO and ABS1

module cycle_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_ops_pkg::byte_t     db,
    input  cpu_ops_pkg::ctl_word_t ctl,
    output seq_pkg::cycle_state_t  state,
    output logic                   sync
);
    import seq_pkg::*;

    cycle_state_t fetch_next;   // First state after the opcode fetch

    always_comb begin
        casez (db)
            8'b1000_0000,
            8'b???1_0000: fetch_next = COND;   // BRA and conditional branches
            8'b1010_00?0,
            8'b11?0_00?0,
            8'b???0_1001: fetch_next = IMM0;
            8'b???1_1001,
            8'b????_11??: fetch_next = ABS0;
            8'b????_01??: fetch_next = ZERO;
            default:      fetch_next = SYNC;   // Implied, next fetch at once
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= INIT;
        end else begin
            case (state)
                INIT:    state <= SYNC;
                SYNC:    state <= fetch_next;
                IMM0:    state <= SYNC;
                ZERO:    state <= ctl.rmw ? RDWR : DATA;
                ABS0:    state <= ABS1;
                ABS1:    state <= ctl.jmp ? SYNC : (ctl.rmw ? RDWR : DATA);
                RDWR:    state <= DATA;
                DATA:    state <= SYNC;
                COND:    state <= SYNC;
                default: state <= INIT;
            endcase
        end
    end

    assign sync = (state == SYNC);

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {INIT, SYNC, IMM0, ZERO, ABS0, ABS1, RDWR, DATA, COND});

    // A taken JMP fetches the next opcode straight after ABS1
    a_jmp_exit: assert property (@(posedge clk) disable iff (rst)
        (state == SYNC && ctl.jmp) |-> $past(state) == ABS1);

endmodule

// File: logic/opcode_decoder.sv
// Opcode decoder
// Latches the control word of the opcode on db in each SYNC cycle.
// The ALU column (low bits 01) is decoded by row, everything else by
// table. Opcodes outside the kept set give an all-zero word

module opcode_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  seq_pkg::cycle_state_t  state,
    input  cpu_ops_pkg::byte_t     db,
    output cpu_ops_pkg::ctl_word_t ctl
);
    import cpu_ops_pkg::*;
    import seq_pkg::*;

    // Word fields: flags, jmp/rmw/st, shift, add, carry, ld, dst, src
    logic [26:0] alu_row;   // ALU column word for the opcode row
    logic [26:0] base;      // Word without index bits
    logic        alu_col;   // ALU column in a kept addressing mode
    logic        known;
    logic        idx_x;
    logic        idx_y;

    assign alu_col = (db[1:0] == 2'b01) && (db[4:2] != 3'b000) && (db[4:2] != 3'b100);

    always_comb begin
        case (db[7:5])
            3'b000:  alu_row = {23'b1000011000_000_00_000_00_1_10, REG_A};  // ORA
            3'b001:  alu_row = {23'b1000011000_000_00_001_00_1_10, REG_A};  // AND
            3'b010:  alu_row = {23'b1000011000_000_00_010_00_1_10, REG_A};  // EOR
            3'b011:  alu_row = {23'b1010011011_000_00_011_11_1_10, REG_A};  // ADC
            3'b100:  alu_row = {23'b0000000000_001_00_100_00_0_00, REG_A};  // STA
            3'b101:  alu_row = {23'b1000011000_000_00_000_00_1_10, REG_Z};  // LDA
            3'b110:  alu_row = {23'b1000011011_000_00_110_01_0_00, REG_A};  // CMP
            default: alu_row = {23'b1010011011_000_00_110_11_1_10, REG_A};  // SBC
        endcase
    end

    always_comb begin
        known = 1'b1;
        case (db)
            // LDX and LDY
            8'hA2, 8'hA6, 8'hAE, 8'hB6, 8'hBE: base = {23'b1000011000_000_00_000_00_1_00, REG_Z};
            8'hA0, 8'hA4, 8'hAC, 8'hB4, 8'hBC: base = {23'b1000011000_000_00_000_00_1_01, REG_Z};
            8'h86, 8'h8E, 8'h96: base = {23'b0000000000_001_00_100_00_0_00, REG_X};  // STX
            8'h84, 8'h8C, 8'h94: base = {23'b0000000000_001_00_100_00_0_00, REG_Y};  // STY
            8'h64, 8'h74, 8'h9C, 8'h9E: base = {23'b0000000000_001_00_100_00_0_00, REG_Z}; // STZ
            8'hE0, 8'hE4, 8'hEC: base = {23'b1000011011_000_00_110_01_0_00, REG_X};  // CPX
            8'hC0, 8'hC4, 8'hCC: base = {23'b1000011011_000_00_110_01_0_00, REG_Y};  // CPY
            8'h24, 8'h2C, 8'h34, 8'h3C: base = {23'b1110001000_000_00_001_00_0_00, REG_A}; // BIT
            8'h89: base = {23'b1100000000_000_00_001_00_0_00, REG_A};  // BIT #, Z only
            8'h06, 8'h0E, 8'h16, 8'h1E: base = {23'b1000011011_010_10_000_00_0_00, REG_Z}; // ASL
            8'h26, 8'h2E, 8'h36, 8'h3E: base = {23'b1000011011_010_10_000_10_0_00, REG_Z}; // ROL
            8'h46, 8'h4E, 8'h56, 8'h5E: base = {23'b1000011011_010_11_000_00_0_00, REG_Z}; // LSR
            8'h66, 8'h6E, 8'h76, 8'h7E: base = {23'b1000011011_010_11_000_10_0_00, REG_Z}; // ROR
            8'hE6, 8'hEE, 8'hF6, 8'hFE: base = {23'b1000011000_010_00_011_00_0_00, 4'd5}; // INC
            8'hC6, 8'hCE, 8'hD6, 8'hDE: base = {23'b1000011000_010_00_011_00_0_00, 4'd6}; // DEC
            8'h0A: base = {23'b1000011011_000_10_100_00_1_10, REG_A};  // ASL A
            8'h2A: base = {23'b1000011011_000_10_100_10_1_10, REG_A};  // ROL A
            8'h4A: base = {23'b1000011011_000_11_100_00_1_10, REG_A};  // LSR A
            8'h6A: base = {23'b1000011011_000_11_100_10_1_10, REG_A};  // ROR A
            8'h1A: base = {23'b1000011000_000_00_100_01_1_10, REG_A};  // INC A
            8'h3A: base = {23'b1000011000_000_00_101_00_1_10, REG_A};  // DEC A
            8'hE8: base = {23'b1000011000_000_00_100_01_1_00, REG_X};  // INX
            8'hC8: base = {23'b1000011000_000_00_100_01_1_01, REG_Y};  // INY
            8'hCA: base = {23'b1000011000_000_00_101_00_1_00, REG_X};  // DEX
            8'h88: base = {23'b1000011000_000_00_101_00_1_01, REG_Y};  // DEY
            8'hAA: base = {23'b1000011000_000_00_100_00_1_00, REG_A};  // TAX
            8'hA8: base = {23'b1000011000_000_00_100_00_1_01, REG_A};  // TAY
            8'h8A: base = {23'b1000011000_000_00_100_00_1_10, REG_X};  // TXA
            8'h98: base = {23'b1000011000_000_00_100_00_1_10, REG_Y};  // TYA
            8'hBA: base = {23'b1000011000_000_00_100_00_1_00, REG_S};  // TSX
            8'h9A: base = {23'b0000000000_000_00_100_00_1_11, REG_X};  // TXS, no flags
            8'h18: base = {23'b0000000011_000_00_000_00_0_00, REG_Z};  // CLC
            8'h38: base = {23'b0000000011_000_00_101_01_0_00, REG_Z};  // SEC
            8'h58, 8'h78: base = {23'b0000100000_000_00_000_00_0_00, REG_Z};  // CLI, SEI
            8'hB8: base = {23'b0010000000_000_00_000_00_0_00, REG_Z};  // CLV
            8'hD8, 8'hF8: base = {23'b0001000000_000_00_000_00_0_00, REG_Z};  // CLD, SED
            8'h4C: base = {23'b0000000000_100_00_000_00_0_00, REG_Z};  // JMP abs
            // Branches and NOP carry no operation
            8'h10, 8'h30, 8'h50, 8'h70, 8'h90,
            8'hB0, 8'hD0, 8'hF0, 8'h80, 8'hEA: base = '0;
            default: begin
                base  = alu_row;
                known = alu_col;
            end
        endcase
    end

    always_comb begin
        idx_x = 1'b0;
        idx_y = 1'b0;
        casez (db)
            8'h96, 8'hB6, 8'hBE: idx_y = 1'b1;   // X loads and stores index by Y
            8'h9C:               idx_x = 1'b0;   // STZ abs
            8'b???1_1001:        idx_y = 1'b1;   // abs,Y
            8'b???1_01??,
            8'b???1_11??:        idx_x = 1'b1;   // zp,X and abs,X
            default:             idx_x = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctl <= '0;
        end else if (state == SYNC) begin
            if (known)
                ctl <= {base[26:17], idx_y, idx_x, base[16:0]};
            else
                ctl <= '0;
        end
    end

endmodule

// File: logic/seq_pkg.sv
// Sequencer definitions for the 65C02-style control unit
// Cycle states of the instruction FSM and the address-path modes.
// The low two mode bits drive the low-byte address mux directly,
// mode bit 2 is the low-byte carry in

package seq_pkg;

    typedef enum logic [3:0] {
        INIT,       // After reset
        SYNC,       // Opcode fetch
        IMM0,       // Immediate operand
        ZERO,       // Zero page address
        ABS0,       // Absolute low byte
        ABS1,       // Absolute high byte
        RDWR,       // Read-modify-write dummy cycle
        DATA,       // Memory operand access
        COND        // Branch offset
    } cycle_state_t;

    typedef logic [3:0] ab_mode_t;

    localparam ab_mode_t MODE_KEEP   = 4'd0;   // Hold AB
    localparam ab_mode_t MODE_PC     = 4'd1;   // Return to PC
    localparam ab_mode_t MODE_ABS    = 4'd2;   // {DB, AHL + index}, save PC
    localparam ab_mode_t MODE_ZP     = 4'd3;   // {00, DB + index}, save PC
    localparam ab_mode_t MODE_NEXT   = 4'd4;   // AB + 1
    localparam ab_mode_t MODE_BRANCH = 4'd7;   // AB + offset + 1

endpackage

// File: logic/cpu_ops_pkg.sv
// Datapath operation types for the 65C02-style control unit
// Operation words for the register file, ALU, status flags and address path,
// plus the control word latched by the opcode decoder

package cpu_ops_pkg;

    typedef logic [7:0]  byte_t;      // Data bus value
    typedef logic [3:0]  reg_sel_t;   // Register source code
    typedef logic [1:0]  reg_dst_t;   // Register destination code
    typedef logic [8:0]  alu_op_t;    // ldm, bcd, shift[1:0], add[2:0], carry[1:0]
    typedef logic [6:0]  reg_op_t;    // write, dst[1:0], src[3:0]
    typedef logic [9:0]  flag_op_t;   // Status flag update mask
    typedef logic [11:0] ab_op_t;     // Address path control

    localparam reg_sel_t REG_X = 4'd0;
    localparam reg_sel_t REG_Y = 4'd1;
    localparam reg_sel_t REG_A = 4'd2;
    localparam reg_sel_t REG_S = 4'd3;
    localparam reg_sel_t REG_Z = 4'd7;    // Reads as zero

    localparam alu_op_t ALU_LOAD_M = 9'b10_00_000_00;   // Load memory operand
    localparam alu_op_t ALU_STORE  = 9'b00_00_100_00;   // Pass source through to memory

    // Per-opcode decode, held for the whole instruction
    typedef struct packed {
        flag_op_t   flag_op;
        logic       add_y;      // Index by Y
        logic       add_x;      // Index by X
        logic       jmp;
        logic       rmw;
        logic       st;
        logic [6:0] alu;        // shift, add, carry
        logic       ld;
        reg_dst_t   dst;
        reg_sel_t   src;
    } ctl_word_t;

endpackage
